/* hdl/rv_core_pkg.sv */
package rv_core_pkg;

    // Major opcodes recognised by the decoder.
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_jal    = 7'b1101111,
        op_system = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_and    = 3'd2,
        alu_or     = 3'd3,
        alu_xor    = 3'd4,
        alu_pass_b = 3'd5
    } alu_op_e;

    // Selects the write-back source in the last stage.
    typedef enum logic [3:0] {
        ir_none = 4'd0,
        ir_alu  = 4'd1,
        ir_link = 4'd2,
        ir_csr  = 4'd3
    } ir_type_e;

    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;
    localparam logic [2:0] FUNCT3_CSRRW   = 3'b001;

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_SUB  = 7'b0100000;

    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;

    // Pipeline register contents after reset form a bubble.
    localparam logic [31:0] DEFAULT_WORD     = 32'h0000_0000;
    localparam logic [4:0]  DEFAULT_REG      = 5'd0;
    localparam logic [11:0] DEFAULT_CSR_ADDR = 12'h000;
    localparam ir_type_e    DEFAULT_IR_TYPE  = ir_none;
    localparam logic        DEFAULT_WR_N     = 1'b1;

endpackage

/* hdl/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1_idx,
    input  logic [4:0]  rs2_idx,
    input  logic        we,
    input  logic [4:0]  wr_idx,
    input  logic [31:0] wr_data,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'h0000_0000;
            end
        end else if (we && (wr_idx != 5'd0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // x0 is hardwired to zero.
    assign rs1_data = (rs1_idx == 5'd0) ? 32'h0000_0000 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == 5'd0) ? 32'h0000_0000 : regs[rs2_idx];

endmodule

/* hdl/csr_file.sv */
`timescale 1ns/1ps

module csr_file import rv_core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [11:0] raddr,
    input  logic        we,
    input  logic [11:0] waddr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);

    logic [31:0] mscratch;
    logic [31:0] mtvec;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mscratch <= 32'h0000_0000;
            mtvec    <= 32'h0000_0000;
        end else if (we) begin
            if (waddr == CSR_MSCRATCH) begin
                mscratch <= wdata;
            end
            if (waddr == CSR_MTVEC) begin
                mtvec <= wdata;
            end
        end
    end

    always_comb begin
        case (raddr)
            CSR_MSCRATCH: rdata = mscratch;
            CSR_MTVEC:    rdata = mtvec;
            default:      rdata = 32'h0000_0000;
        endcase
    end

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import rv_core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        interlock,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    output logic [4:0]  rs1_idx,
    output logic [4:0]  rs2_idx,
    output logic [31:0] imm,
    output logic        use_imm,
    output alu_op_e     alu_op,
    output logic [31:0] dec_pc,
    output logic [4:0]  rd,
    output logic [11:0] csr_addr,
    output ir_type_e    ir_type,
    output logic        wr_reg_n,
    output logic        wr_csr_n
);

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [4:0]  rd_field;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] nxt_imm;
    logic        nxt_use_imm;
    alu_op_e     nxt_alu_op;
    ir_type_e    nxt_type;
    logic        reg_we;
    logic        csr_we;
    logic        nxt_wr_reg_n;
    logic        nxt_wr_csr_n;

    assign opcode   = opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rd_field = instr[11:7];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'h000};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        nxt_imm     = imm_i;
        nxt_use_imm = 1'b0;
        nxt_alu_op  = alu_add;
        nxt_type    = ir_none;
        reg_we      = 1'b0;
        csr_we      = 1'b0;
        case (opcode)
            op_reg: begin
                nxt_type = ir_alu;
                reg_we   = 1'b1;
                case ({funct7, funct3})
                    {FUNCT7_BASE, FUNCT3_ADD_SUB}: nxt_alu_op = alu_add;
                    {FUNCT7_SUB, FUNCT3_ADD_SUB}:  nxt_alu_op = alu_sub;
                    {FUNCT7_BASE, FUNCT3_AND}:     nxt_alu_op = alu_and;
                    {FUNCT7_BASE, FUNCT3_OR}:      nxt_alu_op = alu_or;
                    {FUNCT7_BASE, FUNCT3_XOR}:     nxt_alu_op = alu_xor;
                    default:                       reg_we = 1'b0;
                endcase
            end
            op_imm: begin
                nxt_type    = ir_alu;
                nxt_use_imm = 1'b1;
                reg_we      = (funct3 == FUNCT3_ADD_SUB);
            end
            op_lui: begin
                nxt_type    = ir_alu;
                nxt_imm     = imm_u;
                nxt_use_imm = 1'b1;
                nxt_alu_op  = alu_pass_b;
                reg_we      = 1'b1;
            end
            op_jal: begin
                nxt_type = ir_link;
                nxt_imm  = imm_j;
                reg_we   = 1'b1;
            end
            op_system: begin
                nxt_type = ir_csr;
                reg_we   = (funct3 == FUNCT3_CSRRW);
                csr_we   = (funct3 == FUNCT3_CSRRW);
            end
            default: nxt_type = ir_none;
        endcase
    end

    // A write to x0 never reaches the register file.
    assign nxt_wr_reg_n = !(instr_valid && reg_we && (rd_field != 5'd0));
    assign nxt_wr_csr_n = !(instr_valid && csr_we);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rs1_idx  <= DEFAULT_REG;
            rs2_idx  <= DEFAULT_REG;
            imm      <= DEFAULT_WORD;
            use_imm  <= 1'b0;
            alu_op   <= alu_add;
            dec_pc   <= DEFAULT_WORD;
            rd       <= DEFAULT_REG;
            csr_addr <= DEFAULT_CSR_ADDR;
            ir_type  <= DEFAULT_IR_TYPE;
            wr_reg_n <= DEFAULT_WR_N;
            wr_csr_n <= DEFAULT_WR_N;
        end else if (!interlock) begin
            rs1_idx  <= instr[19:15];
            rs2_idx  <= instr[24:20];
            imm      <= nxt_imm;
            use_imm  <= nxt_use_imm;
            alu_op   <= nxt_alu_op;
            dec_pc   <= pc;
            rd       <= rd_field;
            csr_addr <= instr[31:20];
            ir_type  <= (nxt_wr_reg_n && nxt_wr_csr_n) ? ir_none : nxt_type;
            wr_reg_n <= nxt_wr_reg_n;
            wr_csr_n <= nxt_wr_csr_n;
        end
    end

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import rv_core_pkg::*; (
    input  logic [4:0]  rs1_idx,
    input  logic [4:0]  rs2_idx,
    input  logic [31:0] imm,
    input  logic        use_imm,
    input  alu_op_e     alu_op,
    input  logic [31:0] dec_pc,
    input  logic [4:0]  rd,
    input  logic [11:0] csr_addr,
    input  ir_type_e    ir_type,
    input  logic        wr_reg_n,
    input  logic        wr_csr_n,
    input  logic [31:0] rf_rs1_data,
    input  logic [31:0] rf_rs2_data,
    input  logic [31:0] csr_rdata,
    input  logic [4:0]  fwd_rd,
    input  logic        fwd_wr_reg_n,
    input  logic [31:0] fwd_data,
    input  logic [11:0] fwd_csr_addr,
    input  logic        fwd_wr_csr_n,
    input  logic [31:0] fwd_csr_data,
    output logic [31:0] pc4_in,
    output logic [31:0] c_in,
    output logic [31:0] d_in,
    output logic [31:0] z_in,
    output logic [4:0]  rd_in,
    output logic [11:0] csr_addr_in,
    output ir_type_e    ir_type_in,
    output logic        wr_reg_n_in,
    output logic        wr_csr_n_in
);

    logic        fwd_rs1;
    logic        fwd_rs2;
    logic        fwd_csr;
    logic        csr_known;
    logic [31:0] op_a;
    logic [31:0] rs2_val;
    logic [31:0] op_b;

    // The mem_wb entry has not been written to the files yet.
    assign fwd_rs1 = !fwd_wr_reg_n && (fwd_rd == rs1_idx) && (rs1_idx != 5'd0);
    assign fwd_rs2 = !fwd_wr_reg_n && (fwd_rd == rs2_idx) && (rs2_idx != 5'd0);

    // Unknown CSRs drop writes, so a pending write to one must not be forwarded.
    assign csr_known = (csr_addr == CSR_MSCRATCH) || (csr_addr == CSR_MTVEC);
    assign fwd_csr   = !fwd_wr_csr_n && (fwd_csr_addr == csr_addr) && csr_known;

    assign op_a    = fwd_rs1 ? fwd_data : rf_rs1_data;
    assign rs2_val = fwd_rs2 ? fwd_data : rf_rs2_data;
    assign op_b    = use_imm ? imm : rs2_val;

    always_comb begin
        case (alu_op)
            alu_add:    c_in = op_a + op_b;
            alu_sub:    c_in = op_a - op_b;
            alu_and:    c_in = op_a & op_b;
            alu_or:     c_in = op_a | op_b;
            alu_xor:    c_in = op_a ^ op_b;
            alu_pass_b: c_in = op_b;
            default:    c_in = op_a + op_b;
        endcase
    end

    assign pc4_in = dec_pc + 32'd4;
    assign d_in   = fwd_csr ? fwd_csr_data : csr_rdata;
    assign z_in   = op_a;

    assign rd_in       = rd;
    assign csr_addr_in = csr_addr;
    assign ir_type_in  = ir_type;
    assign wr_reg_n_in = wr_reg_n;
    assign wr_csr_n_in = wr_csr_n;

endmodule

/* hdl/mem_wb_regs.sv */
`timescale 1ns/1ps

module mem_wb_regs import rv_core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        interlock,
    input  logic [31:0] pc4_in,
    input  logic [31:0] c_in,
    input  logic [31:0] d_in,
    input  logic [31:0] z_in,
    input  logic [4:0]  rd_in,
    input  logic [11:0] csr_addr_in,
    input  ir_type_e    ir_type_in,
    input  logic        wr_reg_n_in,
    input  logic        wr_csr_n_in,
    output logic [31:0] pc4_out,
    output logic [31:0] c_out,
    output logic [31:0] d_out,
    output logic [31:0] z_out,
    output logic [4:0]  rd_out,
    output logic [11:0] csr_addr_out,
    output ir_type_e    ir_type_out,
    output logic        wr_reg_n_out,
    output logic        wr_csr_n_out
);

    // The entry stays put while interlock is high.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc4_out      <= DEFAULT_WORD;
            c_out        <= DEFAULT_WORD;
            d_out        <= DEFAULT_WORD;
            z_out        <= DEFAULT_WORD;
            rd_out       <= DEFAULT_REG;
            csr_addr_out <= DEFAULT_CSR_ADDR;
            ir_type_out  <= DEFAULT_IR_TYPE;
            wr_reg_n_out <= DEFAULT_WR_N;
            wr_csr_n_out <= DEFAULT_WR_N;
        end else if (!interlock) begin
            pc4_out      <= pc4_in;
            c_out        <= c_in;
            d_out        <= d_in;
            z_out        <= z_in;
            rd_out       <= rd_in;
            csr_addr_out <= csr_addr_in;
            ir_type_out  <= ir_type_in;
            wr_reg_n_out <= wr_reg_n_in;
            wr_csr_n_out <= wr_csr_n_in;
        end
    end

endmodule

/* hdl/writeback_stage.sv */
`timescale 1ns/1ps

module writeback_stage import rv_core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        interlock,
    input  logic [31:0] pc4,
    input  logic [31:0] c,
    input  logic [31:0] d,
    input  logic [31:0] z,
    input  logic [4:0]  rd,
    input  logic [11:0] csr_addr,
    input  ir_type_e    ir_type,
    input  logic        wr_reg_n,
    input  logic        wr_csr_n,
    input  logic [4:0]  rs1_idx,
    input  logic [4:0]  rs2_idx,
    input  logic [11:0] csr_raddr,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    output logic [31:0] csr_rdata,
    output logic [31:0] wb_data_fwd,
    output logic        wb_valid,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data
);

    logic [31:0] wb_sel;
    logic        reg_we;
    logic        csr_we;

    always_comb begin
        case (ir_type)
            ir_alu:  wb_sel = c;
            ir_link: wb_sel = pc4;
            ir_csr:  wb_sel = d;
            default: wb_sel = 32'h0000_0000;
        endcase
    end

    // A held entry is written once, on the edge after interlock drops.
    assign reg_we = !wr_reg_n && !interlock;
    assign csr_we = !wr_csr_n && !interlock;

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .we       (reg_we),
        .wr_idx   (rd),
        .wr_data  (wb_sel),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    csr_file u_csr_file (
        .clk   (clk),
        .rst_n (rst_n),
        .raddr (csr_raddr),
        .we    (csr_we),
        .waddr (csr_addr),
        .wdata (z),
        .rdata (csr_rdata)
    );

    assign wb_data_fwd = wb_sel;
    assign wb_valid    = reg_we;
    assign wb_rd       = rd;
    assign wb_data     = wb_sel;

endmodule

/* hdl/rv_pipe_top.sv */
`timescale 1ns/1ps

module rv_pipe_top import rv_core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        interlock,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    output logic        wb_valid,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data
);

    logic [4:0]  rs1_idx;
    logic [4:0]  rs2_idx;
    logic [31:0] imm;
    logic        use_imm;
    alu_op_e     alu_op;
    logic [31:0] dec_pc;
    logic [4:0]  dec_rd;
    logic [11:0] dec_csr_addr;
    ir_type_e    dec_ir_type;
    logic        dec_wr_reg_n;
    logic        dec_wr_csr_n;

    logic [31:0] pc4_in;
    logic [31:0] c_in;
    logic [31:0] d_in;
    logic [31:0] z_in;
    logic [4:0]  rd_in;
    logic [11:0] csr_addr_in;
    ir_type_e    ir_type_in;
    logic        wr_reg_n_in;
    logic        wr_csr_n_in;

    logic [31:0] pc4_out;
    logic [31:0] c_out;
    logic [31:0] d_out;
    logic [31:0] z_out;
    logic [4:0]  rd_out;
    logic [11:0] csr_addr_out;
    ir_type_e    ir_type_out;
    logic        wr_reg_n_out;
    logic        wr_csr_n_out;

    logic [31:0] rf_rs1_data;
    logic [31:0] rf_rs2_data;
    logic [31:0] csr_rdata;
    logic [31:0] wb_data_fwd;

    decode_stage u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .interlock   (interlock),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .imm         (imm),
        .use_imm     (use_imm),
        .alu_op      (alu_op),
        .dec_pc      (dec_pc),
        .rd          (dec_rd),
        .csr_addr    (dec_csr_addr),
        .ir_type     (dec_ir_type),
        .wr_reg_n    (dec_wr_reg_n),
        .wr_csr_n    (dec_wr_csr_n)
    );

    execute_stage u_execute (
        .rs1_idx      (rs1_idx),
        .rs2_idx      (rs2_idx),
        .imm          (imm),
        .use_imm      (use_imm),
        .alu_op       (alu_op),
        .dec_pc       (dec_pc),
        .rd           (dec_rd),
        .csr_addr     (dec_csr_addr),
        .ir_type      (dec_ir_type),
        .wr_reg_n     (dec_wr_reg_n),
        .wr_csr_n     (dec_wr_csr_n),
        .rf_rs1_data  (rf_rs1_data),
        .rf_rs2_data  (rf_rs2_data),
        .csr_rdata    (csr_rdata),
        .fwd_rd       (rd_out),
        .fwd_wr_reg_n (wr_reg_n_out),
        .fwd_data     (wb_data_fwd),
        .fwd_csr_addr (csr_addr_out),
        .fwd_wr_csr_n (wr_csr_n_out),
        .fwd_csr_data (z_out),
        .pc4_in       (pc4_in),
        .c_in         (c_in),
        .d_in         (d_in),
        .z_in         (z_in),
        .rd_in        (rd_in),
        .csr_addr_in  (csr_addr_in),
        .ir_type_in   (ir_type_in),
        .wr_reg_n_in  (wr_reg_n_in),
        .wr_csr_n_in  (wr_csr_n_in)
    );

    mem_wb_regs u_mem_wb (
        .clk          (clk),
        .rst_n        (rst_n),
        .interlock    (interlock),
        .pc4_in       (pc4_in),
        .c_in         (c_in),
        .d_in         (d_in),
        .z_in         (z_in),
        .rd_in        (rd_in),
        .csr_addr_in  (csr_addr_in),
        .ir_type_in   (ir_type_in),
        .wr_reg_n_in  (wr_reg_n_in),
        .wr_csr_n_in  (wr_csr_n_in),
        .pc4_out      (pc4_out),
        .c_out        (c_out),
        .d_out        (d_out),
        .z_out        (z_out),
        .rd_out       (rd_out),
        .csr_addr_out (csr_addr_out),
        .ir_type_out  (ir_type_out),
        .wr_reg_n_out (wr_reg_n_out),
        .wr_csr_n_out (wr_csr_n_out)
    );

    writeback_stage u_writeback (
        .clk         (clk),
        .rst_n       (rst_n),
        .interlock   (interlock),
        .pc4         (pc4_out),
        .c           (c_out),
        .d           (d_out),
        .z           (z_out),
        .rd          (rd_out),
        .csr_addr    (csr_addr_out),
        .ir_type     (ir_type_out),
        .wr_reg_n    (wr_reg_n_out),
        .wr_csr_n    (wr_csr_n_out),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .csr_raddr   (dec_csr_addr),
        .rs1_data    (rf_rs1_data),
        .rs2_data    (rf_rs2_data),
        .csr_rdata   (csr_rdata),
        .wb_data_fwd (wb_data_fwd),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

endmodule

/* verif/rv_pipe_tb.sv */
`timescale 1ns/1ps

module rv_pipe_tb import rv_core_pkg::*; ();

    localparam int          MAX_STEPS   = 128;
    localparam logic [6:0]  OPC_IMM     = 7'b0010011;
    localparam logic [6:0]  OPC_LOAD    = 7'b0000011;
    localparam logic [6:0]  OPC_SYSTEM  = 7'b1110011;
    localparam logic [11:0] CSR_UNKNOWN = 12'h7c0;

    typedef struct packed {
        logic        v;
        logic        lk;
        logic [31:0] word;
        logic [31:0] pc;
        logic        exp_v;
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
    } step_t;

    logic        clk;
    logic        rst_n;
    logic        interlock;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    step_t       steps [MAX_STEPS];
    int          num_steps = 0;
    logic [31:0] next_pc = 32'h0000_0100;
    logic [31:0] ref_regs [32];
    logic [31:0] ref_mscratch;
    logic [31:0] ref_mtvec;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    rv_pipe_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .interlock   (interlock),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] itype_word(input logic [11:0] imm12, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [6:0] opc);
        return {imm12, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] upper, input logic [4:0] rd);
        return {upper, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] csrrw_word(input logic [11:0] csr, input logic [4:0] rs1,
                                               input logic [4:0] rd);
        return {csr, rs1, 3'b001, rd, OPC_SYSTEM};
    endfunction

    task automatic append_row(input logic v, input logic lk, input logic [31:0] word);
        step_t s;
        s      = '0;
        s.v    = v;
        s.lk   = lk;
        s.word = word;
        s.pc   = next_pc;
        steps[num_steps] = s;
        num_steps = num_steps + 1;
        next_pc   = next_pc + 32'd4;
    endtask

    task automatic issue_instr(input logic [31:0] word);
        append_row(1'b1, 1'b0, word);
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            append_row(1'b0, 1'b0, 32'h0000_0000);
        end
    endtask

    task automatic hold_cycle(input logic v, input logic [31:0] word);
        append_row(v, 1'b1, word);
    endtask

    // Architectural effect of one instruction, applied in program order.
    task automatic execute_reference(input logic [31:0] word, input logic [31:0] at_pc,
                                     output logic has_result, output logic [4:0] dest,
                                     output logic [31:0] value);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] csr;
        logic [31:0] a;
        logic [31:0] b;
        logic        writes;
        opc    = word[6:0];
        f3     = word[14:12];
        f7     = word[31:25];
        csr    = word[31:20];
        dest   = word[11:7];
        a      = ref_regs[word[19:15]];
        b      = ref_regs[word[24:20]];
        value  = 32'h0000_0000;
        writes = 1'b0;
        case (opc)
            7'b0110011: begin
                writes = 1'b1;
                case ({f7, f3})
                    {7'h00, 3'b000}: value = a + b;
                    {7'h20, 3'b000}: value = a - b;
                    {7'h00, 3'b111}: value = a & b;
                    {7'h00, 3'b110}: value = a | b;
                    {7'h00, 3'b100}: value = a ^ b;
                    default:         writes = 1'b0;
                endcase
            end
            OPC_IMM: begin
                writes = (f3 == 3'b000);
                value  = a + {{20{word[31]}}, word[31:20]};
            end
            7'b0110111: begin
                writes = 1'b1;
                value  = {word[31:12], 12'h000};
            end
            7'b1101111: begin
                writes = 1'b1;
                value  = at_pc + 32'd4;
            end
            OPC_SYSTEM: begin
                if (f3 == 3'b001) begin
                    writes = 1'b1;
                    // Only two CSRs exist. The rest read zero and drop writes.
                    if (csr == CSR_MSCRATCH) begin
                        value        = ref_mscratch;
                        ref_mscratch = a;
                    end else if (csr == CSR_MTVEC) begin
                        value     = ref_mtvec;
                        ref_mtvec = a;
                    end
                end
            end
            default: writes = 1'b0;
        endcase
        has_result = writes && (dest != 5'd0);
        if (has_result) begin
            ref_regs[dest] = value;
        end
    endtask

    // Two-slot timing model of decode and mem_wb that fills the expected columns.
    task automatic predict_results();
        step_t       s;
        logic        dec_v;
        logic [4:0]  dec_rd;
        logic [31:0] dec_val;
        logic        out_v;
        logic [4:0]  out_rd;
        logic [31:0] out_val;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = 32'h0000_0000;
        end
        ref_mscratch = 32'h0000_0000;
        ref_mtvec    = 32'h0000_0000;
        dec_v   = 1'b0;
        dec_rd  = 5'd0;
        dec_val = 32'h0000_0000;
        out_v   = 1'b0;
        out_rd  = 5'd0;
        out_val = 32'h0000_0000;
        for (int i = 0; i < num_steps; i++) begin
            s = steps[i];
            s.exp_v    = out_v && !s.lk;
            s.exp_rd   = out_rd;
            s.exp_data = out_val;
            // Interlock freezes both slots and drops the strobe.
            if (!s.lk) begin
                out_v   = dec_v;
                out_rd  = dec_rd;
                out_val = dec_val;
                if (s.v) begin
                    execute_reference(s.word, s.pc, dec_v, dec_rd, dec_val);
                end else begin
                    dec_v = 1'b0;
                end
            end
            steps[i] = s;
        end
    endtask

    task automatic check_step(input int idx);
        step_t s;
        s = steps[idx];
        assert (wb_valid === s.exp_v) else begin
            $display("[FAIL] %0t step %0d: wb_valid is %0b, expected %0b",
                     $time, idx, wb_valid, s.exp_v);
            $display("TESTS FAILED");
            $fatal(1, "wb_valid did not match the expected value.");
        end
        if (s.exp_v) begin
            assert (wb_rd === s.exp_rd) else begin
                $display("[FAIL] %0t step %0d: wb_rd is %0d, expected %0d",
                         $time, idx, wb_rd, s.exp_rd);
                $display("TESTS FAILED");
                $fatal(1, "wb_rd did not match the expected value.");
            end
            assert (wb_data === s.exp_data) else begin
                $display("[FAIL] %0t step %0d: wb_data is %h, expected %h",
                         $time, idx, wb_data, s.exp_data);
                $display("TESTS FAILED");
                $fatal(1, "wb_data did not match the expected value.");
            end
        end
    endtask

    task automatic build_program();
        logic [11:0] imm_a;
        logic [11:0] imm_b;
        logic [11:0] imm_c;
        logic [11:0] imm_d;
        imm_a = 12'($urandom());
        imm_b = 12'($urandom());
        imm_c = 12'($urandom());
        imm_d = 12'($urandom());
        idle_cycles(3);
        // Dependent ALU chain.
        issue_instr(itype_word(imm_a, 5'd0, 3'b000, 5'd1, OPC_IMM));
        issue_instr(itype_word(imm_b, 5'd1, 3'b000, 5'd2, OPC_IMM));
        issue_instr(rtype_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        issue_instr(rtype_word(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
        issue_instr(rtype_word(7'h00, 5'd2, 5'd4, 3'b111, 5'd5));
        issue_instr(rtype_word(7'h00, 5'd3, 5'd5, 3'b110, 5'd6));
        issue_instr(rtype_word(7'h00, 5'd1, 5'd6, 3'b100, 5'd7));
        issue_instr(lui_word(20'habcde, 5'd8));
        issue_instr(rtype_word(7'h00, 5'd7, 5'd8, 3'b000, 5'd9));
        idle_cycles(1);
        issue_instr(rtype_word(7'h00, 5'd9, 5'd9, 3'b000, 5'd10));
        idle_cycles(2);
        issue_instr(rtype_word(7'h20, 5'd8, 5'd10, 3'b000, 5'd11));
        issue_instr(jal_word(21'h000100, 5'd12));
        issue_instr(rtype_word(7'h00, 5'd0, 5'd12, 3'b000, 5'd13));
        // CSR swaps back to back and after a gap
        issue_instr(csrrw_word(CSR_MSCRATCH, 5'd1, 5'd14));
        issue_instr(csrrw_word(CSR_MSCRATCH, 5'd2, 5'd15));
        idle_cycles(1);
        issue_instr(csrrw_word(CSR_MSCRATCH, 5'd3, 5'd16));
        issue_instr(csrrw_word(CSR_MTVEC, 5'd4, 5'd17));
        issue_instr(csrrw_word(CSR_MTVEC, 5'd0, 5'd18));
        issue_instr(csrrw_word(CSR_UNKNOWN, 5'd5, 5'd19));
        issue_instr(csrrw_word(CSR_UNKNOWN, 5'd6, 5'd20));
        issue_instr(csrrw_word(CSR_MSCRATCH, 5'd7, 5'd0));
        issue_instr(csrrw_word(CSR_MSCRATCH, 5'd0, 5'd21));
        // Unsupported encodings and writes to x0 give no result.
        issue_instr(itype_word(12'h000, 5'd0, 3'b010, 5'd1, OPC_LOAD));
        issue_instr(rtype_word(7'h01, 5'd2, 5'd1, 3'b000, 5'd22));
        issue_instr(itype_word(12'h005, 5'd1, 3'b000, 5'd0, OPC_IMM));
        issue_instr(rtype_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
        issue_instr(lui_word(20'h12345, 5'd0));
        issue_instr(itype_word(12'h005, 5'd1, 3'b010, 5'd23, OPC_IMM));
        issue_instr(itype_word(CSR_MSCRATCH, 5'd1, 3'b010, 5'd24, OPC_SYSTEM));
        issue_instr(32'h0000_0073);
        append_row(1'b0, 1'b0, rtype_word(7'h00, 5'd1, 5'd1, 3'b000, 5'd25));
        idle_cycles(2);
        // Interlock with a pending result, then with both slots full.
        issue_instr(itype_word(imm_c, 5'd1, 3'b000, 5'd26, OPC_IMM));
        idle_cycles(1);
        hold_cycle(1'b0, 32'h0000_0000);
        idle_cycles(2);
        issue_instr(itype_word(imm_d, 5'd26, 3'b000, 5'd27, OPC_IMM));
        issue_instr(rtype_word(7'h00, 5'd27, 5'd27, 3'b000, 5'd28));
        hold_cycle(1'b1, itype_word(12'h001, 5'd0, 3'b000, 5'd29, OPC_IMM));
        hold_cycle(1'b0, 32'h0000_0000);
        issue_instr(rtype_word(7'h00, 5'd29, 5'd28, 3'b000, 5'd30));
        idle_cycles(2);
        hold_cycle(1'b1, itype_word(12'h007, 5'd0, 3'b000, 5'd31, OPC_IMM));
        idle_cycles(2);
        issue_instr(rtype_word(7'h00, 5'd29, 5'd31, 3'b000, 5'd23));
        idle_cycles(4);
    endtask

    initial begin
        step_t s;
        rst_n       <= 1'b0;
        interlock   <= 1'b0;
        instr_valid <= 1'b0;
        instr       <= 32'h0000_0000;
        pc          <= 32'h0000_0000;
        void'($urandom(47));
        build_program();
        predict_results();
        cycle_limit = num_steps * 2 + 40;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < num_steps; i++) begin
            @(posedge clk);
            s = steps[i];
            instr_valid <= s.v;
            interlock   <= s.lk;
            instr       <= s.word;
            pc          <= s.pc;
            @(negedge clk);
            check_step(i);
        end
        $display("TESTS PASSED");
        $finish;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("TESTS FAILED");
            $fatal(1, "Timeout after %0d cycles before the last step was checked.",
                   cycle_count);
        end
    end

endmodule

/* flist.f */
hdl/rv_core_pkg.sv
hdl/reg_file.sv
hdl/csr_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_wb_regs.sv
hdl/writeback_stage.sv
hdl/rv_pipe_top.sv
verif/rv_pipe_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it.
# The exit status of the simulation is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module rv_pipe_tb -o rv_pipe_sim

./obj_dir/rv_pipe_sim
